//--- include/mem_access_defs.svh
`ifndef MEM_ACCESS_DEFS_SVH
`define MEM_ACCESS_DEFS_SVH

// datapath widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// local data RAM, in 32-bit words
`define RAM_WORDS 256

// csr numbers used by the exception check
`define CSR_CRMD  14'h0000
`define CSR_ECFG  14'h0004
`define CSR_ESTAT 14'h0005

// csr values out of reset
`define CSR_CRMD_RST  32'h0000_0008 // DA mode with IE clear
`define CSR_ECFG_RST  32'h0000_0000
`define CSR_ESTAT_RST 32'h0000_0000

`endif

//--- hw/la_mem_pkg.sv
`include "mem_access_defs.svh"

package la_mem_pkg;

    typedef logic [`DATA_WIDTH-1:0]   data_t;
    typedef logic [`ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`DATA_WIDTH/8-1:0] strb_t;
    typedef logic [13:0]              csr_addr_t;
    typedef logic [4:0]               reg_idx_t;

    // ine has the highest priority
    typedef logic [2:0] ex_flags_t;
    localparam int FLAG_INE = 0;
    localparam int FLAG_SYS = 1;
    localparam int FLAG_BRK = 2;

    typedef enum logic [3:0] {
        LD_B     = 4'b0000,
        LD_H     = 4'b0001,
        LD_W     = 4'b0010,
        ST_B     = 4'b0100,
        ST_H     = 4'b0101,
        ST_W     = 4'b0110,
        LD_BU    = 4'b1000,
        LD_HU    = 4'b1001,
        LSU_NONE = 4'b1111  // plain alu result
    } lsu_op_e;

    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_INT  = 3'd1,
        EXC_INE  = 3'd2,
        EXC_SYS  = 3'd3,
        EXC_BRK  = 3'd4,
        EXC_ALE  = 3'd5
    } except_e;

endpackage

//--- hw/mem_req_if.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

interface mem_req_if;

    logic                      en;
    logic                      we;
    logic [`ADDR_WIDTH-3:0]    addr;  // word address
    la_mem_pkg::strb_t         wstrb;
    la_mem_pkg::data_t         wdata;
    la_mem_pkg::data_t         rdata;

    modport master (
        output en, we, addr, wstrb, wdata,
        input  rdata
    );

    modport slave (
        input  en, we, addr, wstrb, wdata,
        output rdata
    );

endinterface

//--- hw/lsu_align.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module lsu_align (
    // request side
    input  la_mem_pkg::lsu_op_e op,
    input  la_mem_pkg::addr_t   addr,
    input  la_mem_pkg::data_t   wdata,
    input  logic                fire,
    input  logic                kill,
    output logic                misaligned,
    mem_req_if.master           mem,
    // response side
    input  la_mem_pkg::lsu_op_e rsp_op,
    input  logic [1:0]          rsp_off,
    output la_mem_pkg::data_t   rdata_out,
    input  la_mem_pkg::data_t   mem_rdata
);

    logic              is_load;
    logic              is_store;
    logic [1:0]        off;
    la_mem_pkg::strb_t strb;
    la_mem_pkg::data_t shifted;

    assign off      = addr[1:0];
    assign is_load  = op inside {la_mem_pkg::LD_B, la_mem_pkg::LD_H, la_mem_pkg::LD_W,
                                 la_mem_pkg::LD_BU, la_mem_pkg::LD_HU};
    assign is_store = op inside {la_mem_pkg::ST_B, la_mem_pkg::ST_H, la_mem_pkg::ST_W};

    // size from the low two opcode bits
    always_comb begin
        misaligned = 1'b0;
        strb       = 4'b0000;
        if (is_load || is_store) begin
            case (op[1:0])
                2'b00: strb = 4'b0001 << off;
                2'b01: begin
                    strb       = 4'b0011 << off;
                    misaligned = (off == 2'd3);
                end
                default: begin
                    strb       = 4'b1111;
                    misaligned = (off != 2'd0);
                end
            endcase
        end
    end

    assign mem.en    = fire && (is_load || is_store);
    assign mem.we    = fire && is_store && !kill;
    assign mem.addr  = addr[`ADDR_WIDTH-1:2];
    assign mem.wstrb = (is_store && !kill) ? strb : 4'b0000;
    assign mem.wdata = wdata << {off, 3'b000};

    // lowest addressed byte moved to bit 0
    assign shifted = mem_rdata >> {rsp_off, 3'b000};

    always_comb begin
        case (rsp_op)
            la_mem_pkg::LD_B:  rdata_out = {{24{shifted[7]}}, shifted[7:0]};
            la_mem_pkg::LD_H:  rdata_out = {{16{shifted[15]}}, shifted[15:0]};
            la_mem_pkg::LD_BU: rdata_out = {24'b0, shifted[7:0]};
            la_mem_pkg::LD_HU: rdata_out = {16'b0, shifted[15:0]};
            default:           rdata_out = shifted;
        endcase
    end

endmodule

//--- hw/data_ram.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module data_ram (
    input logic      clk,
    mem_req_if.slave mem
);

    localparam int IDX_W = $clog2(`RAM_WORDS);

    la_mem_pkg::data_t mem_q [`RAM_WORDS];
    logic [IDX_W-1:0]  idx;

    assign idx = mem.addr[IDX_W-1:0]; // upper address bits ignored

    always_ff @(posedge clk) begin
        if (mem.en) begin
            mem.rdata <= mem_q[idx]; // old data on a write
            for (int i = 0; i < 4; i++) begin
                if (mem.we && mem.wstrb[i]) begin
                    mem_q[idx][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- hw/except_judge.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module except_judge (
    input  la_mem_pkg::ex_flags_t in_flags,
    input  logic                  misaligned,
    input  la_mem_pkg::data_t     csr_crmd,
    input  la_mem_pkg::data_t     csr_ecfg,
    input  la_mem_pkg::data_t     csr_estat,
    input  logic                  fwd_we,
    input  la_mem_pkg::csr_addr_t fwd_addr,
    input  la_mem_pkg::data_t     fwd_data,
    output la_mem_pkg::except_e   except
);

    la_mem_pkg::data_t crmd;
    la_mem_pkg::data_t ecfg;
    la_mem_pkg::data_t estat;
    logic              int_pend;

    // newer value from a write-back csr write wins
    assign crmd  = (fwd_we && fwd_addr == `CSR_CRMD)  ? fwd_data : csr_crmd;
    assign ecfg  = (fwd_we && fwd_addr == `CSR_ECFG)  ? fwd_data : csr_ecfg;
    assign estat = (fwd_we && fwd_addr == `CSR_ESTAT) ? fwd_data : csr_estat;

    // global IE plus any enabled pending line
    assign int_pend = crmd[2] && |(estat[12:0] & ecfg[12:0]);

    always_comb begin
        if (int_pend) begin
            except = la_mem_pkg::EXC_INT;
        end else if (in_flags[la_mem_pkg::FLAG_INE]) begin
            except = la_mem_pkg::EXC_INE;
        end else if (in_flags[la_mem_pkg::FLAG_SYS]) begin
            except = la_mem_pkg::EXC_SYS;
        end else if (in_flags[la_mem_pkg::FLAG_BRK]) begin
            except = la_mem_pkg::EXC_BRK;
        end else if (misaligned) begin
            except = la_mem_pkg::EXC_ALE;
        end else begin
            except = la_mem_pkg::EXC_NONE;
        end
    end

endmodule

//--- hw/mem_access.sv
`timescale 1ns/10ps

module mem_access (
    input  logic                  clk,
    input  logic                  rst,
    // from execute
    input  logic                  in_valid,
    output logic                  in_ready,
    input  la_mem_pkg::addr_t     in_pc,
    input  la_mem_pkg::lsu_op_e   in_op,
    input  la_mem_pkg::addr_t     in_addr,
    input  la_mem_pkg::data_t     in_wdata,
    input  la_mem_pkg::reg_idx_t  in_rd,
    input  logic                  in_rd_we,
    input  la_mem_pkg::ex_flags_t in_flags,
    // csr state and write-back forwarding
    input  la_mem_pkg::data_t     csr_crmd,
    input  la_mem_pkg::data_t     csr_ecfg,
    input  la_mem_pkg::data_t     csr_estat,
    input  logic                  fwd_we,
    input  la_mem_pkg::csr_addr_t fwd_addr,
    input  la_mem_pkg::data_t     fwd_data,
    // to write-back
    output logic                  out_valid,
    input  logic                  out_ready,
    output la_mem_pkg::addr_t     out_pc,
    output la_mem_pkg::reg_idx_t  out_rd,
    output logic                  out_rd_we,
    output la_mem_pkg::data_t     out_data,
    output la_mem_pkg::except_e   out_except
);

    logic                advance;
    logic                fire;
    logic                misaligned;
    la_mem_pkg::except_e a_except;
    la_mem_pkg::data_t   load_data;

    // stage B
    logic                 b_valid;
    la_mem_pkg::addr_t    b_pc;
    la_mem_pkg::lsu_op_e  b_op;
    logic [1:0]           b_off;
    la_mem_pkg::data_t    b_result;
    la_mem_pkg::reg_idx_t b_rd;
    logic                 b_rd_we;
    la_mem_pkg::except_e  b_except;

    mem_req_if i_mem_req ();

    assign advance  = !b_valid || out_ready;
    assign in_ready = advance;
    assign fire     = in_valid && advance;

    except_judge i_except_judge (
        .in_flags   (in_flags),
        .misaligned (misaligned),
        .csr_crmd   (csr_crmd),
        .csr_ecfg   (csr_ecfg),
        .csr_estat  (csr_estat),
        .fwd_we     (fwd_we),
        .fwd_addr   (fwd_addr),
        .fwd_data   (fwd_data),
        .except     (a_except)
    );

    lsu_align i_lsu_align (
        .op         (in_op),
        .addr       (in_addr),
        .wdata      (in_wdata),
        .fire       (fire),
        .kill       (a_except != la_mem_pkg::EXC_NONE), // no store on any exception
        .misaligned (misaligned),
        .mem        (i_mem_req.master),
        .rsp_op     (b_op),
        .rsp_off    (b_off),
        .rdata_out  (load_data),
        .mem_rdata  (i_mem_req.rdata)
    );

    data_ram i_data_ram (
        .clk (clk),
        .mem (i_mem_req.slave)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            b_valid <= 1'b0;
        end else if (advance) begin
            b_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            b_pc     <= in_pc;
            b_op     <= in_op;
            b_off    <= in_addr[1:0];
            b_result <= in_addr;
            b_rd     <= in_rd;
            b_rd_we  <= in_rd_we && (a_except == la_mem_pkg::EXC_NONE);
            b_except <= a_except;
        end
    end

    assign out_valid  = b_valid;
    assign out_pc     = b_pc;
    assign out_rd     = b_rd;
    assign out_rd_we  = b_rd_we;
    assign out_except = b_except;

    // stores and pass-through ops return the execute result
    assign out_data = (b_op inside {la_mem_pkg::LD_B, la_mem_pkg::LD_H, la_mem_pkg::LD_W,
                                    la_mem_pkg::LD_BU, la_mem_pkg::LD_HU})
                      ? load_data : b_result;

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- dv/mem_access_checker.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module mem_access_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  la_mem_pkg::addr_t     in_pc,
    input  la_mem_pkg::lsu_op_e   in_op,
    input  la_mem_pkg::addr_t     in_addr,
    input  la_mem_pkg::data_t     in_wdata,
    input  la_mem_pkg::reg_idx_t  in_rd,
    input  logic                  in_rd_we,
    input  la_mem_pkg::ex_flags_t in_flags,
    input  la_mem_pkg::data_t     csr_crmd,
    input  la_mem_pkg::data_t     csr_ecfg,
    input  la_mem_pkg::data_t     csr_estat,
    input  logic                  fwd_we,
    input  la_mem_pkg::csr_addr_t fwd_addr,
    input  la_mem_pkg::data_t     fwd_data,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  la_mem_pkg::addr_t     out_pc,
    input  la_mem_pkg::reg_idx_t  out_rd,
    input  logic                  out_rd_we,
    input  la_mem_pkg::data_t     out_data,
    input  la_mem_pkg::except_e   out_except,
    output int                    errors,
    output int                    pending
);

    typedef struct packed {
        la_mem_pkg::addr_t    pc;
        la_mem_pkg::reg_idx_t rd;
        logic                 rd_we;
        la_mem_pkg::data_t    data;
        logic                 data_chk; // off for loads that raised an exception
        la_mem_pkg::except_e  exc;
    } exp_t;

    logic [7:0] mem_model [256]; // byte model of the low 64 words
    exp_t       exp_q [$];
    int         err_count  = 0;
    int         accepted   = 0;
    int         checked    = 0;
    int         depth      = 0;
    logic       after_rst  = 1'b0;
    logic       fired_prev = 1'b0;

    assign errors  = err_count;
    assign pending = depth;

    function automatic la_mem_pkg::data_t csr_value(input la_mem_pkg::csr_addr_t num,
                                                    input la_mem_pkg::data_t     csr_in);
        return (fwd_we && fwd_addr == num) ? fwd_data : csr_in;
    endfunction

    function automatic la_mem_pkg::except_e expect_except(input logic mis);
        la_mem_pkg::data_t crmd;
        la_mem_pkg::data_t ecfg;
        la_mem_pkg::data_t estat;
        crmd  = csr_value(`CSR_CRMD, csr_crmd);
        ecfg  = csr_value(`CSR_ECFG, csr_ecfg);
        estat = csr_value(`CSR_ESTAT, csr_estat);
        if (crmd[2] && (estat[12:0] & ecfg[12:0]) != 13'd0) return la_mem_pkg::EXC_INT;
        if (in_flags[la_mem_pkg::FLAG_INE]) return la_mem_pkg::EXC_INE;
        if (in_flags[la_mem_pkg::FLAG_SYS]) return la_mem_pkg::EXC_SYS;
        if (in_flags[la_mem_pkg::FLAG_BRK]) return la_mem_pkg::EXC_BRK;
        return mis ? la_mem_pkg::EXC_ALE : la_mem_pkg::EXC_NONE;
    endfunction

    function automatic int size_bytes(input la_mem_pkg::lsu_op_e op);
        case (op)
            la_mem_pkg::LD_H, la_mem_pkg::LD_HU, la_mem_pkg::ST_H: return 2;
            la_mem_pkg::LD_W, la_mem_pkg::ST_W:                   return 4;
            default:                                               return 1;
        endcase
    endfunction

    function automatic logic is_load(input la_mem_pkg::lsu_op_e op);
        return op inside {la_mem_pkg::LD_B, la_mem_pkg::LD_H, la_mem_pkg::LD_W,
                          la_mem_pkg::LD_BU, la_mem_pkg::LD_HU};
    endfunction

    function automatic logic is_store(input la_mem_pkg::lsu_op_e op);
        return op inside {la_mem_pkg::ST_B, la_mem_pkg::ST_H, la_mem_pkg::ST_W};
    endfunction

    // byte at the address lands in bits 7:0
    function automatic la_mem_pkg::data_t load_value(input la_mem_pkg::lsu_op_e op,
                                                     input logic [7:0]          a);
        logic [31:0] w;
        w = {mem_model[a + 8'd3], mem_model[a + 8'd2], mem_model[a + 8'd1], mem_model[a]};
        case (op)
            la_mem_pkg::LD_B:  return {{24{w[7]}}, w[7:0]};
            la_mem_pkg::LD_BU: return {24'd0, w[7:0]};
            la_mem_pkg::LD_H:  return {{16{w[15]}}, w[15:0]};
            la_mem_pkg::LD_HU: return {16'd0, w[15:0]};
            default:           return w;
        endcase
    endfunction

    task automatic accept_input();
        exp_t       e;
        int         n;
        logic       mis;
        logic [7:0] a;
        a   = in_addr[7:0];
        n   = size_bytes(in_op);
        mis = (n == 2 && a[1:0] == 2'd3) || (n == 4 && a[1:0] != 2'd0);
        e.pc       = in_pc;
        e.rd       = in_rd;
        e.exc      = expect_except(mis);
        e.rd_we    = in_rd_we && e.exc == la_mem_pkg::EXC_NONE;
        e.data     = is_load(in_op) ? load_value(in_op, a) : in_addr;
        e.data_chk = !is_load(in_op) || e.exc == la_mem_pkg::EXC_NONE;
        if (is_store(in_op) && e.exc == la_mem_pkg::EXC_NONE) begin
            for (int i = 0; i < n; i++) begin
                mem_model[a + i[7:0]] = in_wdata[8*i +: 8];
            end
        end
        exp_q.push_back(e);
        accepted++;
    endtask

    task automatic check_value(input string             name,
                               input la_mem_pkg::data_t got,
                               input la_mem_pkg::data_t want);
        if (got !== want) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, want, got);
            err_count++;
        end
    endtask

    task automatic compare_output();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("Error at %0t ns: output transfer with no operation outstanding", $time);
            err_count++;
        end else begin
            e = exp_q.pop_front();
            checked++;
            check_value("out_pc", out_pc, e.pc);
            check_value("out_rd", 32'(out_rd), 32'(e.rd));
            check_value("out_rd_we", 32'(out_rd_we), 32'(e.rd_we));
            check_value("out_except", 32'(out_except), 32'(e.exc));
            if (e.data_chk) begin
                check_value("out_data", out_data, e.data);
            end
        end
    endtask

    task automatic report_counts();
        $display("checker: %0d accepted, %0d outputs checked, %0d errors",
                 accepted, checked, err_count);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            after_rst  = 1'b1;
            fired_prev = 1'b0;
        end else begin
            if (after_rst && (out_valid !== 1'b0 || in_ready !== 1'b1)) begin
                $display("Error at %0t ns: pipeline not empty and ready after reset", $time);
                err_count++;
            end
            // ready whenever stage B is empty or draining
            if (in_ready !== (!out_valid || out_ready)) begin
                $display("Error at %0t ns: in_ready expected %b, got %b", $time,
                         !out_valid || out_ready, in_ready);
                err_count++;
            end
            if (fired_prev && out_valid !== 1'b1) begin
                $display("Error at %0t ns: no output one cycle after an input transfer", $time);
                err_count++;
            end
            if (out_valid && out_ready) begin
                compare_output(); // older op leaves before the new one enters
            end
            if (in_valid && in_ready) begin
                accept_input();
            end
            after_rst  = 1'b0;
            fired_prev = in_valid && in_ready;
            depth      = exp_q.size();
        end
    end

endmodule

//--- dv/mem_access_tb.sv
`timescale 1ns/10ps
`include "mem_access_defs.svh"

module mem_access_tb;

    localparam int NUM_INIT   = 64; // one full-word store per model word
    localparam int NUM_RANDOM = 2000;
    localparam int MAX_CYCLES = 5 * NUM_RANDOM;

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    la_mem_pkg::addr_t     in_pc;
    la_mem_pkg::lsu_op_e   in_op;
    la_mem_pkg::addr_t     in_addr;
    la_mem_pkg::data_t     in_wdata;
    la_mem_pkg::reg_idx_t  in_rd;
    logic                  in_rd_we;
    la_mem_pkg::ex_flags_t in_flags;
    la_mem_pkg::data_t     csr_crmd;
    la_mem_pkg::data_t     csr_ecfg;
    la_mem_pkg::data_t     csr_estat;
    logic                  fwd_we;
    la_mem_pkg::csr_addr_t fwd_addr;
    la_mem_pkg::data_t     fwd_data;
    logic                  out_valid;
    logic                  out_ready = 1'b1;
    la_mem_pkg::addr_t     out_pc;
    la_mem_pkg::reg_idx_t  out_rd;
    logic                  out_rd_we;
    la_mem_pkg::data_t     out_data;
    la_mem_pkg::except_e   out_except;
    int                    errors;
    int                    pending;
    int                    cycles = 0;
    logic                  bp_on  = 1'b0;

    tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

    mem_access i_dut (.*);

    mem_access_checker i_checker (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        out_ready <= bp_on ? (($urandom % 10) >= 3) : 1'b1; // about 30% stalls
        if (cycles >= MAX_CYCLES) begin
            i_checker.report_counts();
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // holds one operation until the DUT takes it
    task automatic drive_op(input logic init, input int idx);
        logic [31:0]           r;
        logic [31:0]           s;
        la_mem_pkg::lsu_op_e   op;
        la_mem_pkg::csr_addr_t fa;
        logic [1:0]            lo;
        r = $urandom;
        s = $urandom;
        case (s % 9)
            0:       op = la_mem_pkg::LD_B;
            1:       op = la_mem_pkg::LD_H;
            2:       op = la_mem_pkg::LD_W;
            3:       op = la_mem_pkg::ST_B;
            4:       op = la_mem_pkg::ST_H;
            5:       op = la_mem_pkg::ST_W;
            6:       op = la_mem_pkg::LD_BU;
            7:       op = la_mem_pkg::LD_HU;
            default: op = la_mem_pkg::LSU_NONE;
        endcase
        lo = r[1:0];
        if (r[3:2] != 2'b00) begin
            lo = op[1] ? 2'b00 : {r[1], r[0] & ~op[0]}; // mostly size aligned
        end
        case (r[31:30])
            2'd0:    fa = `CSR_CRMD;
            2'd1:    fa = `CSR_ECFG;
            2'd2:    fa = `CSR_ESTAT;
            default: fa = s[31:18];
        endcase
        in_valid  <= 1'b1;
        in_op     <= init ? la_mem_pkg::ST_W : op;
        in_addr   <= init ? 32'(idx * 4)
                   : (op == la_mem_pkg::LSU_NONE) ? s : {24'd0, r[9:4], lo};
        in_wdata  <= $urandom;
        in_pc     <= $urandom & 32'hffff_fffc;
        in_rd     <= r[27:23];
        in_rd_we  <= r[28];
        // about one op in sixteen carries flags
        in_flags  <= (init || r[19:16] != 4'd0) ? 3'b000
                   : ((r[22:20] == 3'd0) ? 3'b100 : r[22:20]);
        csr_crmd  <= init ? `CSR_CRMD_RST : {28'd0, 1'b1, r[15], 2'b00};
        csr_ecfg  <= init ? `CSR_ECFG_RST : {19'd0, s[12:0]};
        csr_estat <= (init || r[14:12] != 3'd0) ? `CSR_ESTAT_RST : (32'd1 << s[16:13]);
        fwd_we    <= !init && r[11:10] == 2'b00;
        fwd_addr  <= fa;
        fwd_data  <= $urandom;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h43cbbc10));
        in_valid  = 1'b0;
        in_pc     = '0;
        in_op     = la_mem_pkg::LSU_NONE;
        in_addr   = '0;
        in_wdata  = '0;
        in_rd     = '0;
        in_rd_we  = 1'b0;
        in_flags  = 3'b000;
        csr_crmd  = `CSR_CRMD_RST;
        csr_ecfg  = `CSR_ECFG_RST;
        csr_estat = `CSR_ESTAT_RST;
        fwd_we    = 1'b0;
        fwd_addr  = '0;
        fwd_data  = '0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        // fill the RAM so no load reads an unwritten word
        for (int i = 0; i < NUM_INIT; i++) begin
            drive_op(1'b1, i);
        end
        bp_on <= 1'b1;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            if ($urandom % 4 == 0) begin
                repeat (1 + $urandom % 3) @(posedge clk);
            end
            drive_op(1'b0, i);
        end
        // checker counts settle between rising edges
        repeat (2) @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
        i_checker.report_counts();
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- mem_access.f
+incdir+include
hw/la_mem_pkg.sv
hw/mem_req_if.sv
hw/lsu_align.sv
hw/data_ram.sv
hw/except_judge.sv
hw/mem_access.sv
dv/tb_clk_gen.sv
dv/mem_access_checker.sv
dv/mem_access_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mem_access testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module mem_access_tb \
    -f mem_access.f -o mem_access_sim

./obj_dir/mem_access_sim > sim.log 2>&1
cat sim.log

if grep -q "^All tests passed$" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
